/* logic/dbg_mem_pkg.sv */
/*
  shared definitions for the hart-facing memory window of the debug module
  holds the address map, bus and hart widths, abstract command field
  positions, error codes and the jal encoder used for the WHERETO word
  every block of the window imports this package with a wildcard
*/
package dbg_mem_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int unsigned NrHarts     = 4;
  localparam int unsigned HartSelLen  = 2;
  localparam int unsigned BusWidth    = 32;
  localparam int unsigned BeWidth     = 4;
  localparam int unsigned DbgAddrBits = 12;
  localparam int unsigned DataCount   = 2;
  localparam int unsigned NrRegions   = 8;

  typedef logic [NrHarts-1:0]                   hart_vec_t;
  typedef logic [HartSelLen-1:0]                hart_idx_t;
  typedef logic [BusWidth-1:0]                  bus_word_t;
  typedef logic [BeWidth-1:0]                   bus_be_t;
  typedef logic [DbgAddrBits-1:0]               dbg_addr_t;
  typedef logic [31:0]                          cmd_word_t;
  typedef logic [DataCount-1:0][BusWidth-1:0]   data_regs_t;
  typedef logic [NrRegions-1:0]                 region_t;
  typedef logic [2:0]                           cmderr_t;

  // ----------------------------------------------------------------------
  // address map, low 12 bits of the window
  // ----------------------------------------------------------------------
  localparam dbg_addr_t HaltedAddr      = 12'h100;
  localparam dbg_addr_t GoingAddr       = 12'h104;
  localparam dbg_addr_t ResumingAddr    = 12'h108;
  localparam dbg_addr_t ExceptionAddr   = 12'h10C;
  localparam dbg_addr_t WhereToAddr     = 12'h300;
  localparam dbg_addr_t AbstractCmdAddr = 12'h358;
  localparam dbg_addr_t DataBaseAddr    = 12'h380;
  localparam dbg_addr_t DataEndAddr     = 12'h387;
  localparam dbg_addr_t FlagsBaseAddr   = 12'h400;
  localparam dbg_addr_t FlagsEndAddr    = 12'h7FF;
  // resume entry of the hart, only the low bits enter the jump offset
  localparam dbg_addr_t ResumeAddr      = 12'h810;

  // one-hot region indices
  localparam int unsigned RegHalted    = 0;
  localparam int unsigned RegGoing     = 1;
  localparam int unsigned RegResuming  = 2;
  localparam int unsigned RegException = 3;
  localparam int unsigned RegWhereTo   = 4;
  localparam int unsigned RegData      = 5;
  localparam int unsigned RegFlags     = 6;
  localparam int unsigned RegNone      = 7;

  // byte enables a write has to cover for each register width
  localparam bus_be_t FullBeMask = 4'b1111;
  localparam bus_be_t Byte0Mask  = 4'b0001;

  // abstract command fields
  localparam int unsigned CmdTypeLsb  = 24;
  localparam int unsigned AarSizeLsb  = 20;
  localparam int unsigned PostIncBit  = 19;
  localparam int unsigned RegnoTopLsb = 14;
  localparam logic [7:0] AccessRegister = 8'd0;
  localparam logic [2:0] MaxAarSize     = 3'd3;

  localparam cmderr_t CmdErrNone         = 3'd0;
  localparam cmderr_t CmdErrNotSupported = 3'd2;
  localparam cmderr_t CmdErrException    = 3'd3;
  localparam cmderr_t CmdErrHaltResume   = 3'd4;

  typedef enum logic [1:0] {Idle, Go, Resume, CmdExecuting} cmd_state_e;

  // J-type jal with rd = x0, offset in bytes
  function automatic bus_word_t jal_word(logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

endpackage

/* logic/dbg_bus_decode.sv */
/*
  address decoder of the debug memory window
  turns each bus request into a one-hot region and flags bus errors
  region_o is combinational, err_o is valid the cycle after the request
*/
`timescale 1ns/1ps

module dbg_bus_decode
  import dbg_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  bus_word_t addr_i,
  input  bus_be_t   be_i,
  output region_t   region_o,
  output logic      err_o
);

  logic    misaligned;
  bus_be_t be_mask;
  logic    err_d;
  logic    err_q;

  // word accesses only
  assign misaligned = |addr_i[1:0];

  // ----------------------------------------------------------------------
  // region decode
  // ----------------------------------------------------------------------
  always_comb begin
    region_o = '0;
    case (addr_i[DbgAddrBits-1:0]) inside
      HaltedAddr:                   region_o[RegHalted]    = 1'b1;
      GoingAddr:                    region_o[RegGoing]     = 1'b1;
      ResumingAddr:                 region_o[RegResuming]  = 1'b1;
      ExceptionAddr:                region_o[RegException] = 1'b1;
      WhereToAddr:                  region_o[RegWhereTo]   = 1'b1;
      [DataBaseAddr:DataEndAddr]:   region_o[RegData]      = 1'b1;
      [FlagsBaseAddr:FlagsEndAddr]: region_o[RegFlags]     = 1'b1;
      default:                      region_o[RegNone]      = 1'b1;
    endcase
    // idle cycles and misaligned accesses touch nothing
    if (!req_i || misaligned) begin
      region_o          = '0;
      region_o[RegNone] = 1'b1;
    end
  end

  // mailbox words only carry a hart index or a single bit
  always_comb begin
    be_mask = FullBeMask;
    if (region_o[RegHalted] || region_o[RegGoing] ||
        region_o[RegResuming] || region_o[RegException]) begin
      be_mask = Byte0Mask;
    end
  end

  // unmapped or misaligned, or a write narrower than the register
  assign err_d = req_i && (region_o[RegNone] || (we_i && |(~be_i & be_mask)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_d;
    end
  end

  assign err_o = err_q;

endmodule

/* logic/dbg_hart_status.sv */
/*
  per-hart halted and resuming flags
  harts report their state by writing their index to the mailbox words,
  the GOING and EXCEPTION writes become one-cycle pulses for the FSM
*/
`timescale 1ns/1ps

module dbg_hart_status
  import dbg_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      we_i,
  input  region_t   region_i,
  input  bus_word_t wdata_i,
  input  hart_idx_t hartsel_i,
  input  logic      clear_resumeack_i,
  input  logic      ndmreset_i,
  output hart_vec_t halted_o,
  output hart_vec_t resuming_o,
  output logic      halted_ev_o,
  output logic      going_o,
  output logic      exception_o
);

  hart_idx_t wdata_hart;
  hart_vec_t halted_d, halted_q;
  hart_vec_t resuming_d, resuming_q;

  // the writing hart puts its own index in the low bits
  assign wdata_hart = wdata_i[HartSelLen-1:0];

  // pulses, only the selected hart ends a running command
  assign halted_ev_o = we_i && region_i[RegHalted] && (wdata_hart == hartsel_i);
  assign going_o     = we_i && region_i[RegGoing];
  assign exception_o = we_i && region_i[RegException];

  always_comb begin
    halted_d   = halted_q;
    resuming_d = resuming_q;
    // debugger acknowledged the resume
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end
    if (we_i && region_i[RegHalted]) begin
      halted_d[wdata_hart] = 1'b1;
    end
    // hart left debug mode
    if (we_i && region_i[RegResuming]) begin
      halted_d[wdata_hart]   = 1'b0;
      resuming_d[wdata_hart] = 1'b1;
    end
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

endmodule

/* logic/dbg_cmd_fsm.sv */
/*
  command and resume FSM of the debug memory window
  accepts one-cycle abstract command pulses, checks them and sequences the
  go and resume flags that the harts poll, errors answer combinationally
*/
`timescale 1ns/1ps

module dbg_cmd_fsm
  import dbg_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmd_valid_i,
  input  cmd_word_t cmd_i,
  input  hart_idx_t hartsel_i,
  input  hart_vec_t haltreq_i,
  input  hart_vec_t resumereq_i,
  input  hart_vec_t halted_i,
  input  hart_vec_t resuming_i,
  input  logic      halted_ev_i,
  input  logic      going_i,
  input  logic      exception_i,
  input  logic      ndmreset_i,
  output logic      go_o,
  output logic      resume_o,
  output logic      cmdbusy_o,
  output logic      cmderror_valid_o,
  output cmderr_t   cmderror_o
);

  cmd_state_e state_d, state_q;
  logic       unsupported;
  logic       resume_ok;

  // only register access, up to 32 bit, no postincrement, no reserved regno
  assign unsupported = (cmd_i[CmdTypeLsb +: 8] != AccessRegister) ||
                       (cmd_i[AarSizeLsb +: 3] >= MaxAarSize) ||
                       cmd_i[PostIncBit] ||
                       (cmd_i[RegnoTopLsb +: 2] != 2'b00);

  // resume is ignored while a halt is requested or the last ack is pending
  assign resume_ok = resumereq_i[hartsel_i] && halted_i[hartsel_i] &&
                     !resuming_i[hartsel_i] && !haltreq_i[hartsel_i];

  assign cmdbusy_o = (state_q != Idle);

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmderror_valid_o = 1'b0;
    cmderror_o       = CmdErrNone;
    case (state_q)
      Idle: begin
        if (cmd_valid_i && halted_i[hartsel_i] && !unsupported) begin
          state_d = Go;
        end else if (cmd_valid_i) begin
          // hart must be halted
          cmderror_valid_o = 1'b1;
          cmderror_o       = CmdErrHaltResume;
        end
        if (resume_ok) begin
          state_d = Resume;
        end
      end
      // hart polls go until it jumps to the command area
      Go: begin
        go_o = 1'b1;
        if (going_i) begin
          state_d = CmdExecuting;
        end
      end
      Resume: begin
        resume_o = 1'b1;
        if (resuming_i[hartsel_i]) begin
          state_d = Idle;
        end
      end
      // wait for the hart to come back to the park loop
      CmdExecuting: begin
        if (halted_ev_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase

    // higher priority errors override
    if (cmd_valid_i && unsupported) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrNotSupported;
    end
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrException;
    end

    if (ndmreset_i) begin
      state_d  = Idle;
      go_o     = 1'b0;
      resume_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* logic/dbg_read_path.sv */
/*
  data register write merge and registered read data of the window
  hart writes to the data registers leave as a merged word with a valid
  pulse, reads of WHERETO, data and flags answer one cycle later
*/
`timescale 1ns/1ps

module dbg_read_path
  import dbg_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       we_i,
  input  region_t    region_i,
  input  bus_word_t  addr_i,
  input  bus_word_t  wdata_i,
  input  bus_be_t    be_i,
  input  hart_idx_t  hartsel_i,
  input  hart_vec_t  resumereq_i,
  input  data_regs_t data_i,
  input  logic       go_i,
  input  logic       resume_i,
  input  logic       cmdbusy_i,
  output data_regs_t data_o,
  output logic       data_valid_o,
  output bus_word_t  rdata_o
);

  logic [$clog2(DataCount)-1:0] data_idx;
  dbg_addr_t                    flag_addr;
  bus_word_t                    rdata_d, rdata_q;

  assign data_idx  = addr_i[2 +: $clog2(DataCount)];
  // byte of the selected hart inside the flags area
  assign flag_addr = FlagsBaseAddr + dbg_addr_t'(hartsel_i);

  // ----------------------------------------------------------------------
  // data register writes
  // ----------------------------------------------------------------------
  always_comb begin
    data_o       = data_i;
    data_valid_o = 1'b0;
    if (we_i && region_i[RegData]) begin
      data_valid_o = 1'b1;
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          data_o[data_idx][b*8 +: 8] = wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // read data
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_d = rdata_q;
    if (!we_i && !region_i[RegNone]) begin
      rdata_d = '0;
      if (region_i[RegWhereTo]) begin
        // pending command wins over resume
        if (cmdbusy_i) begin
          rdata_d = jal_word(21'(AbstractCmdAddr) - 21'(WhereToAddr));
        end else if (resumereq_i[hartsel_i]) begin
          rdata_d = jal_word(21'(ResumeAddr) - 21'(WhereToAddr));
        end
      end
      if (region_i[RegData]) begin
        rdata_d = data_i[data_idx];
      end
      // go in bit 0, resume in bit 1 of the hart's byte
      if (region_i[RegFlags] &&
          (addr_i[DbgAddrBits-1:2] == flag_addr[DbgAddrBits-1:2])) begin
        rdata_d[flag_addr[1:0]*8 +: 8] = {6'b0, resume_i, go_i};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* logic/dbg_mem_top.sv */
/*
  top of the hart-facing debug memory window
  connects the bus decoder, hart status, command FSM and read path to the
  bus, command and hart control ports, with no logic of its own
*/
`timescale 1ns/1ps

module dbg_mem_top
  import dbg_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // bus
  input  logic       req_i,
  input  logic       we_i,
  input  bus_word_t  addr_i,
  input  bus_word_t  wdata_i,
  input  bus_be_t    be_i,
  output bus_word_t  rdata_o,
  output logic       err_o,
  // abstract commands
  input  logic       cmd_valid_i,
  input  cmd_word_t  cmd_i,
  output logic       cmderror_valid_o,
  output cmderr_t    cmderror_o,
  output logic       cmdbusy_o,
  // hart control
  input  hart_idx_t  hartsel_i,
  input  hart_vec_t  haltreq_i,
  input  hart_vec_t  resumereq_i,
  input  logic       clear_resumeack_i,
  input  logic       ndmreset_i,
  output hart_vec_t  debug_req_o,
  output hart_vec_t  halted_o,
  output hart_vec_t  resuming_o,
  // data registers
  input  data_regs_t data_i,
  output data_regs_t data_o,
  output logic       data_valid_o
);

  region_t region;
  logic    halted_ev, going, exception;
  logic    go, resume;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  dbg_bus_decode u_decode (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .be_i,
    .region_o (region),
    .err_o
  );

  dbg_hart_status u_status (
    .clk_i, .rst_ni, .we_i,
    .region_i (region),
    .wdata_i, .hartsel_i, .clear_resumeack_i, .ndmreset_i,
    .halted_o, .resuming_o,
    .halted_ev_o (halted_ev),
    .going_o     (going),
    .exception_o (exception)
  );

  dbg_cmd_fsm u_fsm (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i, .hartsel_i, .haltreq_i, .resumereq_i,
    .halted_i    (halted_o),
    .resuming_i  (resuming_o),
    .halted_ev_i (halted_ev),
    .going_i     (going),
    .exception_i (exception),
    .ndmreset_i,
    .go_o        (go),
    .resume_o    (resume),
    .cmdbusy_o, .cmderror_valid_o, .cmderror_o
  );

  dbg_read_path u_read (
    .clk_i, .rst_ni, .we_i,
    .region_i (region),
    .addr_i, .wdata_i, .be_i, .hartsel_i, .resumereq_i, .data_i,
    .go_i      (go),
    .resume_i  (resume),
    .cmdbusy_i (cmdbusy_o),
    .data_o, .data_valid_o, .rdata_o
  );

endmodule

/* dv/dbg_mem_tb.sv */
/*
  testbench of the hart-facing debug memory window
  walks dbg_mem_top through the command, resume, data register and
  bus error sequences, stops at the first mismatch
*/
`timescale 1ns/1ps

module dbg_mem_tb;
  import dbg_mem_pkg::*;

  typedef struct packed {
    logic      we;
    bus_word_t addr;
    bus_word_t wdata;
    bus_be_t   be;
    logic      err;
    bus_word_t rdata;
  } bus_op_t;

  localparam cmd_word_t ValidCmd = 32'h0022_1000;  // access register, 32 bit, transfer
  localparam bus_word_t Data0Val = 32'h5a3c_0f81;
  localparam bus_word_t Data1Val = 32'hc0de_7e42;
  localparam int        NrOps    = 9;
  // we, addr, wdata, be, expected err, expected rdata
  localparam bus_op_t Ops [NrOps] = '{
    '{1'b0, 32'h0000_0300, 32'h0, 4'b1111, 1'b0, 32'h0},
    '{1'b0, 32'h0000_0000, 32'h0, 4'b1111, 1'b1, 32'h0},
    '{1'b0, 32'h0000_0102, 32'h0, 4'b1111, 1'b1, 32'h0},
    '{1'b1, 32'h0000_0100, 32'h0, 4'b0010, 1'b1, 32'h0},
    '{1'b0, 32'h0000_0800, 32'h0, 4'b1111, 1'b1, 32'h0},
    '{1'b0, 32'h0000_0380, 32'h0, 4'b1111, 1'b0, Data0Val},
    '{1'b0, 32'h0000_0384, 32'h0, 4'b1111, 1'b0, Data1Val},
    '{1'b1, 32'h0000_0384, 32'h1, 4'b1111, 1'b0, Data1Val},
    '{1'b0, 32'h0000_0400, 32'h0, 4'b1111, 1'b0, 32'h0}
  };

  logic       clk_i, rst_ni, req_i, we_i, err_o;
  bus_word_t  addr_i, wdata_i, rdata_o;
  bus_be_t    be_i;
  logic       cmd_valid_i, cmderror_valid_o, cmdbusy_o;
  cmd_word_t  cmd_i;
  cmderr_t    cmderror_o;
  hart_idx_t  hartsel_i;
  hart_vec_t  haltreq_i, resumereq_i, debug_req_o, halted_o, resuming_o;
  logic       clear_resumeack_i, ndmreset_i, data_valid_o;
  data_regs_t data_i, data_o;

  // values caught by the bus and command tasks
  logic       seen_err, seen_dvalid, seen_ce_valid;
  bus_word_t  seen_rdata;
  data_regs_t seen_data;
  cmderr_t    seen_ce;
  int         seed = 32'h1cc5ba97;

  dbg_mem_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // compare helpers
  // ----------------------------------------------------------------------
  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_hart_vec(input string name, input hart_vec_t got, input hart_vec_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input cmderr_t got, input cmderr_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // jal x0 with the J-type immediate scattered over the word
  function automatic bus_word_t encode_jal(input logic [20:0] off);
    bus_word_t w;
    w        = 32'h0000_006f;
    w[31]    = off[20];
    w[30:21] = off[10:1];
    w[20]    = off[11];
    w[19:12] = off[19:12];
    return w;
  endfunction

  function automatic bus_word_t merge_bytes(input bus_word_t old, input bus_word_t wr,
                                            input bus_be_t be);
    bus_word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old & ~mask) | (wr & mask);
  endfunction

  // ----------------------------------------------------------------------
  // drivers
  // ----------------------------------------------------------------------
  // data port and command error caught mid-cycle, response one cycle later
  task automatic bus_access(input logic we, input bus_word_t addr,
                            input bus_word_t wdata, input bus_be_t be);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    be_i    <= be;
    @(negedge clk_i);
    seen_dvalid   = data_valid_o;
    seen_data     = data_o;
    seen_ce_valid = cmderror_valid_o;
    seen_ce       = cmderror_o;
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
    seen_err   = err_o;
    seen_rdata = rdata_o;
  endtask

  task automatic send_cmd(input cmd_word_t cmd);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    @(negedge clk_i);
    seen_ce_valid = cmderror_valid_o;
    seen_ce       = cmderror_o;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_cmd_idle();
    int cycles;
    cycles = 0;
    while (cmdbusy_o && cycles < 50) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cmdbusy_o) begin
      stop_on_failure("timeout while waiting for cmdbusy_o to return low");
    end
  endtask

  // ----------------------------------------------------------------------
  // sequence
  // ----------------------------------------------------------------------
  initial begin
    data_regs_t old, exp;
    bus_word_t  rnd;
    bus_be_t    be;
    logic       idx;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    hartsel_i = 2'd2;
    haltreq_i = '0;
    resumereq_i = '0;
    clear_resumeack_i = 1'b0;
    ndmreset_i = 1'b0;
    data_i = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b0);
    check_bit("err_o", err_o, 1'b0);
    check_bit("cmderror_valid_o", cmderror_valid_o, 1'b0);
    check_err("cmderror_o", cmderror_o, CmdErrNone);
    check_hart_vec("halted_o", halted_o, 4'b0000);
    check_hart_vec("resuming_o", resuming_o, 4'b0000);
    check_bit("data_valid_o", data_valid_o, 1'b0);
    check_word("rdata_o", rdata_o, 32'h0);

    // hart 2 still running, then halted, then a bad cmdtype
    send_cmd(ValidCmd);
    check_bit("cmderror_valid_o", seen_ce_valid, 1'b1);
    check_err("cmderror_o", seen_ce, CmdErrHaltResume);
    bus_access(1'b1, 32'h100, 32'd2, 4'b0001);
    check_hart_vec("halted_o", halted_o, 4'b0100);
    send_cmd(ValidCmd | 32'h0100_0000);
    check_bit("cmderror_valid_o", seen_ce_valid, 1'b1);
    check_err("cmderror_o", seen_ce, CmdErrNotSupported);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b0);

    // full command round trip
    send_cmd(ValidCmd);
    check_bit("cmderror_valid_o", seen_ce_valid, 1'b0);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b1);
    bus_access(1'b0, 32'h400, 32'h0, 4'b1111);
    check_word("rdata_o", seen_rdata, 32'h0001_0000);
    // 0x358 - 0x300
    bus_access(1'b0, 32'h300, 32'h0, 4'b1111);
    check_word("rdata_o", seen_rdata, encode_jal(21'h058));
    bus_access(1'b1, 32'h104, 32'd2, 4'b0001);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b1);
    bus_access(1'b1, 32'h100, 32'd2, 4'b0001);
    wait_cmd_idle();
    bus_access(1'b1, 32'h10c, 32'd2, 4'b0001);
    check_bit("cmderror_valid_o", seen_ce_valid, 1'b1);
    check_err("cmderror_o", seen_ce, CmdErrException);

    // resume of hart 2
    @(posedge clk_i);
    resumereq_i <= 4'b0100;
    bus_access(1'b0, 32'h400, 32'h0, 4'b1111);
    check_word("rdata_o", seen_rdata, 32'h0002_0000);
    bus_access(1'b1, 32'h108, 32'd2, 4'b0001);
    check_hart_vec("halted_o", halted_o, 4'b0000);
    check_hart_vec("resuming_o", resuming_o, 4'b0100);
    // 0x810 - 0x300 once back in idle
    bus_access(1'b0, 32'h300, 32'h0, 4'b1111);
    check_word("rdata_o", seen_rdata, encode_jal(21'h510));
    @(posedge clk_i);
    resumereq_i       <= 4'b0000;
    clear_resumeack_i <= 1'b1;
    @(posedge clk_i);
    clear_resumeack_i <= 1'b0;
    @(negedge clk_i);
    check_hart_vec("resuming_o", resuming_o, 4'b0000);

    // ndmreset wipes flags and a pending command
    bus_access(1'b1, 32'h100, 32'd2, 4'b0001);
    bus_access(1'b1, 32'h108, 32'd3, 4'b0001);
    send_cmd(ValidCmd);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b1);
    check_hart_vec("resuming_o", resuming_o, 4'b1000);
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    @(posedge clk_i);
    ndmreset_i <= 1'b0;
    @(negedge clk_i);
    check_bit("cmdbusy_o", cmdbusy_o, 1'b0);
    check_hart_vec("halted_o", halted_o, 4'b0000);
    check_hart_vec("resuming_o", resuming_o, 4'b0000);

    // random data register writes
    for (int i = 0; i < 8; i++) begin
      old[0] = $random(seed);
      old[1] = $random(seed);
      rnd    = $random(seed);
      be     = rnd[3:0];
      idx    = rnd[4];
      rnd    = $random(seed);
      @(posedge clk_i);
      data_i <= old;
      bus_access(1'b1, idx ? 32'h384 : 32'h380, rnd, be);
      exp      = old;
      exp[idx] = merge_bytes(old[idx], rnd, be);
      check_bit("data_valid_o", seen_dvalid, 1'b1);
      check_word("data_o[0]", seen_data[0], exp[0]);
      check_word("data_o[1]", seen_data[1], exp[1]);
      check_bit("err_o", seen_err, be != 4'b1111);
      check_bit("data_valid_o", data_valid_o, 1'b0);
    end

    @(posedge clk_i);
    haltreq_i <= 4'b1001;
    data_i[0] <= Data0Val;
    data_i[1] <= Data1Val;
    @(negedge clk_i);
    check_hart_vec("debug_req_o", debug_req_o, 4'b1001);
    @(posedge clk_i);
    haltreq_i <= 4'b0000;

    // bus error table
    for (int n = 0; n < NrOps; n++) begin
      bus_access(Ops[n].we, Ops[n].addr, Ops[n].wdata, Ops[n].be);
      check_bit("err_o", seen_err, Ops[n].err);
      check_word("rdata_o", seen_rdata, Ops[n].rdata);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* vlog.f */
logic/dbg_mem_pkg.sv
logic/dbg_bus_decode.sv
logic/dbg_hart_status.sv
logic/dbg_cmd_fsm.sv
logic/dbg_read_path.sv
logic/dbg_mem_top.sv
dv/dbg_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the debug memory window testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module dbg_mem_tb -o dbg_mem_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/dbg_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
exit 1
